/* tb/aluPatterns.hex */
// kind_aluOp_funct_a_b_imm_result_zero, kind 1 is a request and 0 an idle gap
// aluOp 0 R-type, 1 branch, 2 xori, 3 addi; result and zero are expected values
// R-type add, carry out wraps
1_0_20_00000003_00000004_0000_00000007_0
1_0_20_FFFFFFFF_00000001_0000_00000000_1
1_0_20_80000000_80000000_0000_00000000_1
1_0_20_12345678_9ABCDEF0_0000_ACF13568_0
1_0_20_7FFFFFFF_00000001_0000_80000000_0
// R-type subtract
1_0_22_0000002D_0000002D_0000_00000000_1
1_0_22_0000000A_00000003_0000_00000007_0
1_0_22_00000003_0000000A_0000_FFFFFFF9_0
1_0_22_00000000_00000001_0000_FFFFFFFF_0
1_0_22_80000000_00000001_0000_7FFFFFFF_0
// R-type and, or
1_0_24_F0F0F0F0_0FF00FF0_0000_00F000F0_0
1_0_24_12345678_00000000_0000_00000000_1
1_0_25_F0F0F0F0_0F0F0F0F_0000_FFFFFFFF_0
1_0_25_00000000_00000000_0000_00000000_1
1_0_25_12340000_00005678_0000_12345678_0
// R-type slt, signed compare
1_0_2A_FFFFFFFF_00000005_0000_00000001_0
1_0_2A_00000005_FFFFFFFF_0000_00000000_1
1_0_2A_00000003_00000007_0000_00000001_0
1_0_2A_00000007_00000003_0000_00000000_1
1_0_2A_80000000_7FFFFFFF_0000_00000001_0
1_0_2A_7FFFFFFF_80000000_0000_00000000_1
1_0_2A_FFFFFFFE_FFFFFFFE_0000_00000000_1
1_0_2A_FFFFFFFE_FFFFFFFF_0000_00000001_0
0_0_20_11111111_22222222_0000_33333333_0
// xori, immediate zero extended, b ignored
1_2_00_00000005_DEADBEEF_0006_00000003_0
1_2_00_00000000_DEADBEEF_8000_00008000_0
1_2_00_FFFFFFFF_00000000_FFFF_FFFF0000_0
1_2_00_0000ABCD_00000001_ABCD_00000000_1
// addi, immediate sign extended
1_3_00_0000000A_00000000_FFFF_00000009_0
1_3_00_00001000_00000000_7FFF_00008FFF_0
1_3_00_00000000_12345678_8000_FFFF8000_0
1_3_00_00000001_00000000_FFFF_00000000_1
1_3_00_10000000_00000000_0010_10000010_0
0_3_00_44444444_55555555_FFFF_00000000_0
0_0_22_66666666_77777777_0000_00000000_0
// branch class subtracts, funct ignored
1_1_00_CAFEF00D_CAFEF00D_0000_00000000_1
1_1_00_00000005_00000003_0000_00000002_0
1_1_00_00000003_00000005_0000_FFFFFFFE_0
1_1_24_00000008_00000008_0000_00000000_1
// unlisted function codes give zero
1_0_26_FFFFFFFF_00000001_0000_00000000_1
1_0_00_12345678_00000004_0000_00000000_1
1_0_3F_FFFFFFFF_FFFFFFFF_0000_00000000_1
1_0_21_00000001_00000001_0000_00000000_1
0_0_20_88888888_99999999_0000_00000000_0
// back to back tail
1_0_20_00000001_00000001_0000_00000002_0
1_0_22_FFFFFFFF_FFFFFFFF_0000_00000000_1
1_0_24_FFFFFFFF_12345678_0000_12345678_0

/* project.f */
+incdir+include
design/aluPkg.sv
design/aluDecode.sv
design/aluExecute.sv
design/aluResult.sv
design/aluTop.sv
tb/aluTb.sv

/* run.sh */
#!/bin/sh
# build and run the ALU testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! command -v verilator >/dev/null 2>&1; then
  echo "verilator not found in PATH"
  exit 1
fi

verilator --binary --timing -j 0 -f project.f --top-module aluTb -Mdir obj_dir
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

output=$(./obj_dir/ValuTb)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -qx "TEST OK"; then
  exit 0
else
  echo "pass line not found in simulation output"
  exit 1
fi

/* include/aluChecks.svh */
// ALU response compare tasks
`ifndef ALU_CHECKS_SVH
`define ALU_CHECKS_SVH

// -------------------------------------------------------------------
// result word
// -------------------------------------------------------------------
// stops the run on the first mismatch
task automatic checkResult(
  input aluPkg::word_t expected,
  input aluPkg::word_t actual
);
  // X or Z on the bus counts as a mismatch
  if (actual !== expected) begin
    $display("Error at %0t: result expected %h got %h", $time, expected, actual);
    $display("TEST FAILED");
    $fatal(1, "result word mismatch");
  end
endtask

// -------------------------------------------------------------------
// zero flag
// -------------------------------------------------------------------
// flag against the pattern table, result word shown next to it
task automatic checkZero(
  input logic          expected,
  input logic          actual,
  input aluPkg::word_t result
);
  if (actual !== expected) begin
    $display("Error at %0t: zero expected %b got %b for result %h",
             $time, expected, actual, result);
    $display("TEST FAILED");
    $fatal(1, "zero flag mismatch");
  end
endtask

`endif

/* tb/aluTb.sv */
// ALU subsystem testbench
`timescale 1ns/1ps

module aluTb;

  `include "aluChecks.svh"

  // -------------------------------------------------------------------
  // timing and table sizes
  // -------------------------------------------------------------------
  localparam int clkPeriod     = 10;
  // inputs change this long after the rising edge
  localparam int driveDelay    = 1;
  localparam int resetCycles   = 3;
  // two register stages between request and response
  localparam int latency       = 2;
  localparam int maxLines      = 64;
  // margin on top of one clock per pattern line
  localparam int watchdogSlack = 200;

  // one pattern line of 33 hex digits
  // kind(4) aluOp(4) funct(8) a(32) b(32) imm(16) result(32) zero(4)
  typedef logic [131:0] patLine_t;

  // expected response and the cycle it must show up in
  typedef struct packed {
    aluPkg::aluResp_t resp;
    int               due;
  } expectEntry_t;

  // DUT signals
  logic             begintest;
  logic             rstN;
  logic             inValid;
  aluPkg::aluReq_t  req;
  aluPkg::aluResp_t resp;
  logic             outValid;

  // pattern table, line count and load done flag
  patLine_t     patterns [maxLines];
  int           numLines;
  bit           loaded;
  // rising edges seen so far
  int           cycleCount = 0;
  // responses still owed by the DUT, oldest first
  expectEntry_t expQueue [$];

  // -------------------------------------------------------------------
  // clock and cycle counter
  // -------------------------------------------------------------------
  initial begin
    begintest = 1'b0;
    forever #(clkPeriod / 2) begintest = ~begintest;
  end

  always @(posedge begintest) begin
    cycleCount <= cycleCount + 1;
  end

  // -------------------------------------------------------------------
  // DUT
  // -------------------------------------------------------------------
  aluTop i_dut (
    .begintest (begintest),
    .rstN      (rstN),
    .inValid   (inValid),
    .req       (req),
    .resp      (resp),
    .outValid  (outValid)
  );

  // report why the run stops and end it
  task automatic abortRun(input string reason);
    $display("%s", reason);
    $display("TEST FAILED");
    $fatal(1, "run aborted");
  endtask

  // unused table entries keep a marker plus their index
  task automatic loadPatterns();
    int idx;
    for (idx = 0; idx < maxLines; idx++) begin
      patterns[idx] = {4'hf, 128'(idx)};
    end
    $readmemh("tb/aluPatterns.hex", patterns);
    numLines = 0;
    // table ends at the first entry still holding the marker
    while (numLines < maxLines && patterns[numLines][131:128] != 4'hf) begin
      numLines++;
    end
    if (numLines == 0) begin
      abortRun("no pattern lines could be read from tb/aluPatterns.hex");
    end
  endtask

  // put one line on the inputs and remember what a request should return
  task automatic driveLine(input patLine_t line);
    expectEntry_t entry;
    req.aluOp = line[125:124];
    req.funct = line[121:116];
    req.a     = line[115:84];
    req.b     = line[83:52];
    req.imm   = line[51:36];
    // kind 0 is an idle gap where the operands still toggle
    inValid   = (line[131:128] == 4'h1);
    if (inValid) begin
      entry.resp.result = line[35:4];
      entry.resp.zero   = line[0];
      entry.due         = cycleCount + latency;
      expQueue.push_back(entry);
    end
  endtask

  // -------------------------------------------------------------------
  // reset and stimulus
  // -------------------------------------------------------------------
  initial begin
    int lineIdx;
    rstN    = 1'b0;
    inValid = 1'b0;
    req     = '0;
    loadPatterns();
    loaded = 1'b1;
    repeat (resetCycles) @(posedge begintest);
    #(driveDelay);
    rstN = 1'b1;
    // one line per clock, back to back
    for (lineIdx = 0; lineIdx < numLines; lineIdx++) begin
      @(posedge begintest);
      #(driveDelay);
      driveLine(patterns[lineIdx]);
    end
    @(posedge begintest);
    #(driveDelay);
    inValid = 1'b0;
    req     = '0;
    // drain the pipeline
    while (expQueue.size() != 0) begin
      @(negedge begintest);
    end
    // a few idle cycles to catch a stray strobe
    repeat (3) @(negedge begintest);
    $display("TEST OK");
    $finish;
  end

  // -------------------------------------------------------------------
  // response checker
  // -------------------------------------------------------------------
  // outputs settle after the rising edge and are sampled at the falling edge
  always @(negedge begintest) begin
    expectEntry_t head;
    if (outValid) begin
      if (expQueue.size() == 0) begin
        abortRun($sformatf("outValid high at %0t with no request outstanding", $time));
      end else begin
        head = expQueue.pop_front();
        if (head.due != cycleCount) begin
          abortRun($sformatf("response at cycle %0d, expected at cycle %0d",
                             cycleCount, head.due));
        end else begin
          checkResult(head.resp.result, resp.result);
          checkZero(head.resp.zero, resp.zero, resp.result);
        end
      end
    end else if (expQueue.size() != 0 && expQueue[0].due < cycleCount) begin
      // strobe never came for the oldest request
      abortRun($sformatf("response due at cycle %0d missing at %0t",
                         expQueue[0].due, $time));
    end
  end

  // -------------------------------------------------------------------
  // watchdog
  // -------------------------------------------------------------------
  initial begin
    wait (loaded);
    #(numLines * clkPeriod + watchdogSlack);
    abortRun($sformatf("timeout at %0t with %0d responses still pending",
                       $time, expQueue.size()));
  end

endmodule

/* design/aluTop.sv */
// ALU subsystem top level
`timescale 1ns/1ps

module aluTop (
  input  logic             begintest,
  input  logic             rstN,
  input  logic             inValid,
  input  aluPkg::aluReq_t  req,
  output aluPkg::aluResp_t resp,
  output logic             outValid
);

  // decoded request, combinational from req
  aluPkg::execOp_t decOp;
  // stage one outputs
  aluPkg::word_t   stageResult;
  logic            stageValid;

  // class and function field to operation code, operand select
  aluDecode iDecode (
    .req (req),
    .op  (decOp)
  );

  // compute and register, first cycle of latency
  aluExecute iExecute (
    .begintest   (begintest),
    .rstN        (rstN),
    .inValid     (inValid),
    .op          (decOp),
    .stageResult (stageResult),
    .stageValid  (stageValid)
  );

  // zero flag and response register, second cycle
  aluResult iResult (
    .begintest   (begintest),
    .rstN        (rstN),
    .stageValid  (stageValid),
    .stageResult (stageResult),
    .resp        (resp),
    .outValid    (outValid)
  );

endmodule

/* design/aluResult.sv */
// ALU result stage
`timescale 1ns/1ps

module aluResult (
  input  logic             begintest,
  input  logic             rstN,
  input  logic             stageValid,
  input  aluPkg::word_t    stageResult,
  output aluPkg::aluResp_t resp,
  output logic             outValid
);

  // -------------------------------------------------------------------
  // zero detect
  // -------------------------------------------------------------------
  // wide NOR over the stage one result, off the adder path
  logic             zeroFlag;
  // response as it will be registered
  aluPkg::aluResp_t nextResp;

  assign zeroFlag = (stageResult == '0);

  always_comb begin
    nextResp.result = stageResult;
    nextResp.zero   = zeroFlag;
  end

  // -------------------------------------------------------------------
  // stage two register
  // -------------------------------------------------------------------
  // outValid is a one cycle strobe, there is no hold or stall
  always_ff @(posedge begintest or negedge rstN) begin
    if (!rstN) begin
      resp     <= '0;
      outValid <= 1'b0;
    end else begin
      resp     <= nextResp;
      // bubbles from input gaps pass straight through
      outValid <= stageValid;
    end
  end

endmodule

/* design/aluExecute.sv */
// ALU execute stage
`timescale 1ns/1ps

module aluExecute (
  input  logic                 begintest,
  input  logic                 rstN,
  input  logic                 inValid,
  input  aluPkg::execOp_t      op,
  output aluPkg::word_t        stageResult,
  output logic                 stageValid
);

  // -------------------------------------------------------------------
  // arithmetic and logic
  // -------------------------------------------------------------------
  // adder result wraps modulo 2^32
  aluPkg::word_t sum;
  // difference shared by sub
  aluPkg::word_t diff;
  // signed compare of a against operand
  logic          lessThan;
  // value picked by the operation code
  aluPkg::word_t aluValue;

  assign sum  = op.a + op.operand;
  assign diff = op.a - op.operand;

  // slt compares as two's complement, sign differences included
  assign lessThan = $signed(op.a) < $signed(op.operand);

  always_comb begin
    case (op.ctrl)
      aluPkg::ctrlAdd: begin
        aluValue = sum;
      end
      aluPkg::ctrlSub: begin
        aluValue = diff;
      end
      aluPkg::ctrlAnd: begin
        aluValue = op.a & op.operand;
      end
      aluPkg::ctrlOr: begin
        aluValue = op.a | op.operand;
      end
      aluPkg::ctrlXor: begin
        aluValue = op.a ^ op.operand;
      end
      aluPkg::ctrlSlt: begin
        // single bit result, upper bits clear
        aluValue = {{(aluPkg::wordWidth-1){1'b0}}, lessThan};
      end
      default: begin
        // ctrlZero and any code left over
        aluValue = '0;
      end
    endcase
  end

  // -------------------------------------------------------------------
  // stage one register
  // -------------------------------------------------------------------
  // data is captured every cycle, only the valid bit follows inValid
  always_ff @(posedge begintest or negedge rstN) begin
    if (!rstN) begin
      stageResult <= '0;
      stageValid  <= 1'b0;
    end else begin
      stageResult <= aluValue;
      stageValid  <= inValid;
    end
  end

endmodule

/* design/aluDecode.sv */
// ALU operation decode
`timescale 1ns/1ps

module aluDecode (
  input  aluPkg::aluReq_t req,
  output aluPkg::execOp_t op
);

  // number of upper bits filled when widening the immediate
  localparam int extWidth = aluPkg::wordWidth - aluPkg::immWidth;

  // both immediate flavours for the operand select below
  aluPkg::word_t    immZext;
  aluPkg::word_t    immSext;
  aluPkg::aluCtrl_t ctrl;
  aluPkg::word_t    operand;

  // -------------------------------------------------------------------
  // R-type function field map
  // -------------------------------------------------------------------
  function automatic aluPkg::aluCtrl_t functToCtrl(input aluPkg::funct_t funct);
    aluPkg::aluCtrl_t code;
    case (funct)
      aluPkg::functAdd: code = aluPkg::ctrlAdd;
      aluPkg::functSub: code = aluPkg::ctrlSub;
      aluPkg::functAnd: code = aluPkg::ctrlAnd;
      aluPkg::functOr:  code = aluPkg::ctrlOr;
      aluPkg::functSlt: code = aluPkg::ctrlSlt;
      // unknown function forces the result to zero
      default:          code = aluPkg::ctrlZero;
    endcase
    return code;
  endfunction

  // xori takes the immediate as unsigned
  assign immZext = {{extWidth{1'b0}}, req.imm};
  // addi and load/store offsets are signed
  assign immSext = {{extWidth{req.imm[aluPkg::immWidth-1]}}, req.imm};

  // operation select from class and function field
  always_comb begin
    case (req.aluOp)
      aluPkg::opRtype:  ctrl = functToCtrl(req.funct);
      aluPkg::opBranch: ctrl = aluPkg::ctrlSub;
      aluPkg::opXori:   ctrl = aluPkg::ctrlXor;
      default:          ctrl = aluPkg::ctrlAdd;
    endcase
  end

  // second operand select
  always_comb begin
    case (req.aluOp)
      aluPkg::opXori: operand = immZext;
      aluPkg::opAddi: operand = immSext;
      // R-type and branch compare two registers
      default:        operand = req.b;
    endcase
  end

  // bundle for the execute stage
  always_comb begin
    op.ctrl    = ctrl;
    op.a       = req.a;
    op.operand = operand;
  end

endmodule

/* design/aluPkg.sv */
// ALU subsystem shared definitions
package aluPkg;

  // -------------------------------------------------------------------
  // field widths
  // -------------------------------------------------------------------
  localparam int wordWidth  = 32;
  localparam int immWidth   = 16;
  localparam int functWidth = 6;
  localparam int opWidth    = 2;
  localparam int ctrlWidth  = 3;

  // operand and result word
  typedef logic [wordWidth-1:0]  word_t;
  // raw immediate field of the I-type instruction
  typedef logic [immWidth-1:0]   imm_t;
  // R-type function field
  typedef logic [functWidth-1:0] funct_t;
  // operation class from main control
  typedef logic [opWidth-1:0]    aluOp_t;
  // internal ALU operation code
  typedef logic [ctrlWidth-1:0]  aluCtrl_t;

  // -------------------------------------------------------------------
  // operation classes
  // -------------------------------------------------------------------
  // function field decides the operation
  localparam aluOp_t opRtype  = 2'b00;
  // beq style compare, always subtract
  localparam aluOp_t opBranch = 2'b01;
  localparam aluOp_t opXori   = 2'b10;
  // addi, lw and sw address arithmetic
  localparam aluOp_t opAddi   = 2'b11;

  // internal operation codes, MIPS textbook style where one exists
  localparam aluCtrl_t ctrlAnd  = 3'b000;
  localparam aluCtrl_t ctrlOr   = 3'b001;
  localparam aluCtrl_t ctrlAdd  = 3'b010;
  localparam aluCtrl_t ctrlXor  = 3'b011;
  localparam aluCtrl_t ctrlZero = 3'b100;
  localparam aluCtrl_t ctrlSub  = 3'b110;
  localparam aluCtrl_t ctrlSlt  = 3'b111;

  // R-type function codes
  localparam funct_t functAdd = 6'b100000;
  localparam funct_t functSub = 6'b100010;
  localparam funct_t functAnd = 6'b100100;
  localparam funct_t functOr  = 6'b100101;
  localparam funct_t functSlt = 6'b101010;

  // -------------------------------------------------------------------
  // bundles
  // -------------------------------------------------------------------
  // one request as it arrives from the datapath
  typedef struct packed {
    aluOp_t aluOp;
    funct_t funct;
    word_t  a;
    word_t  b;
    imm_t   imm;
  } aluReq_t;

  // decoded operation, operand already selected
  typedef struct packed {
    aluCtrl_t ctrl;
    word_t    a;
    word_t    operand;
  } execOp_t;

  // one response
  typedef struct packed {
    word_t result;
    logic  zero;
  } aluResp_t;

endpackage
